/* sim.f */
hw/uartPkg.sv
hw/uartRx.sv
hw/uartTx.sv
hw/rxFifo.sv
hw/uartTop.sv
tb/uartTopTb.sv

/* run.sh */
#!/bin/sh
# builds the UART testbench with Verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module uartTopTb \
	-f sim.f -Mdir obj_dir -o uartSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/uartSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi
exit 0

/* tb/uartTopTb.sv */
module uartTopTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClkPeriod = 20;
	localparam int Bit = uartPkg::BaudDiv;      // clocks per serial bit
	localparam int Entries = 8;
	// 14 bit times per table entry and per fill frame plus slack
	localparam int CycleLimit = (Entries + uartPkg::FifoDepth + 1) * 14 * Bit + 100;

	// {loopback, stopGood, data}
	localparam logic [9:0] StimTable [Entries] = '{
		{1'b0, 1'b1, 8'h55},
		{1'b0, 1'b1, 8'hA3},
		{1'b0, 1'b0, 8'h3C},                    // bad stop bit
		{1'b1, 1'b1, 8'hC5},
		{1'b0, 1'b1, 8'h00},
		{1'b0, 1'b1, 8'hFF},
		{1'b1, 1'b1, 8'h81},
		{1'b0, 1'b0, 8'hE7}
	};

	logic iCLK = 1'b0;
	logic iRST;
	logic rxd;
	logic rdStrobe;
	logic sendStrobe;
	uartPkg::byteT sendData;
	logic txd;
	logic rxThru;
	uartPkg::byteT rdData;
	logic rxEmpty;
	logic rxFull;
	logic rxOverflow;
	logic frameErr;
	logic txBusy;
	int cycleCount = 0;
	logic lineAtEdge;                           // rxd as the DUT saw it

	uartTop dut_i
	(
		.iCLK(iCLK), .iRST(iRST), .rxd(rxd), .rdStrobe(rdStrobe),
		.sendStrobe(sendStrobe), .sendData(sendData), .txd(txd), .rxThru(rxThru),
		.rdData(rdData), .rxEmpty(rxEmpty), .rxFull(rxFull), .rxOverflow(rxOverflow),
		.frameErr(frameErr), .txBusy(txBusy)
	);

	always #(ClkPeriod / 2) iCLK = ~iCLK;

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			$display("Testbench failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// ----------------------------------------
	// watchdog and debug copy monitor
	// ----------------------------------------
	always @(posedge iCLK)
	begin
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("TIMEOUT: run still going after %0d cycles", cycleCount);
			$display("Testbench failed");
			$fatal(1, "run stopped by the watchdog");
		end
	end

	always @(posedge iCLK)
	begin
		lineAtEdge <= rxd;
	end

	always @(negedge iCLK)
	begin
		check("rxThru", 32'(rxThru), 32'(lineAtEdge));   // one flop behind rxd
	end

	// ----------------------------------------
	// line model and host helpers
	// ----------------------------------------
	function automatic logic frameBit(input uartPkg::byteT data, input int idx);
		if (idx == 0)
			return 1'b0;                        // start
		else if (idx == 9)
			return 1'b1;                        // stop
		return data[idx - 1];                   // lsb first
	endfunction

	// drives start, 8 data bits and stop while counting frameErr pulses
	task automatic serialFrame(input uartPkg::byteT data, input logic stopGood,
		output int pulses);
		logic [9:0] frame;
		pulses = 0;
		frame = {stopGood, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rxd = frame[i];
			repeat (Bit)
			begin
				@(negedge iCLK);
				if (frameErr)
					pulses++;
			end
		end
		rxd = 1'b1;
	endtask

	// at least one bit of idle line lets a glitch restart settle
	task automatic idleGap();
		int gap;
		gap = Bit + int'($urandom_range(Bit - 1));
		repeat (gap)
		begin
			@(negedge iCLK);
			check("frameErr", 32'(frameErr), 0);
		end
	endtask

	task automatic popByte();
		rdStrobe = 1'b1;
		@(negedge iCLK);
		rdStrobe = 1'b0;
	endtask

	task automatic receiveDirect(input uartPkg::byteT data, input logic stopGood);
		int pulses;
		idleGap();
		serialFrame(data, stopGood, pulses);
		check("frameErr pulses", pulses, stopGood ? 0 : 1);
		if (stopGood)
		begin
			while (rxEmpty)
				@(negedge iCLK);
			check("rdData", 32'(rdData), 32'(data));
			popByte();
		end
		check("rxEmpty", 32'(rxEmpty), 1);     // bad frame never pushed
	endtask

	task automatic sendLoopback(input uartPkg::byteT data);
		int cycles;
		int pulses;
		idleGap();
		sendData = data;
		sendStrobe = 1'b1;
		@(negedge iCLK);
		sendStrobe = 1'b0;
		check("txBusy", 32'(txBusy), 0);
		@(negedge iCLK);
		check("txBusy", 32'(txBusy), 1);       // one edge after the strobe
		cycles = 0;
		pulses = 0;
		while (txBusy)
		begin
			cycles++;
			rxd = txd;                          // transmitter drives the receiver
			if (frameErr)
				pulses++;
			if ((cycles - 1) % Bit == Bit / 2 - 1)
				check("txd", 32'(txd), 32'(frameBit(data, (cycles - 1) / Bit)));
			sendStrobe = (cycles == 5);         // mid-frame request gets dropped
			sendData = ~data;
			@(negedge iCLK);
		end
		sendStrobe = 1'b0;
		rxd = 1'b1;
		check("txBusy cycles", cycles, 10 * Bit);
		check("frameErr pulses", pulses, 0);
		while (rxEmpty)
			@(negedge iCLK);
		check("rdData", 32'(rdData), 32'(data));
		popByte();
		// only one frame may have gone out
		repeat (2 * Bit)
		begin
			@(negedge iCLK);
			check("txBusy", 32'(txBusy), 0);
			check("txd", 32'(txd), 1);
		end
		check("rxEmpty", 32'(rxEmpty), 1);
	endtask

	task automatic fillOverflow();
		uartPkg::byteT sent [uartPkg::FifoDepth + 1];
		int pulses;
		for (int i = 0; i <= uartPkg::FifoDepth; i++)
		begin
			sent[i] = uartPkg::byteT'($urandom);
			idleGap();
			serialFrame(sent[i], 1'b1, pulses);
			check("frameErr pulses", pulses, 0);
			check("rxFull", 32'(rxFull), (i >= uartPkg::FifoDepth - 1) ? 1 : 0);
			check("rxOverflow", 32'(rxOverflow), (i == uartPkg::FifoDepth) ? 1 : 0);
		end
		// ninth byte was dropped
		for (int i = 0; i < uartPkg::FifoDepth; i++)
		begin
			check("rxEmpty", 32'(rxEmpty), 0);
			check("rdData", 32'(rdData), 32'(sent[i]));
			popByte();
		end
		check("rxEmpty", 32'(rxEmpty), 1);
		check("rxFull", 32'(rxFull), 0);
		check("rxOverflow", 32'(rxOverflow), 1);   // sticky
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		void'($urandom(5));
		iRST = 1'b1;
		rxd = 1'b1;                             // idle line
		rdStrobe = 1'b0;
		sendStrobe = 1'b0;
		sendData = '0;
		repeat (4) @(negedge iCLK);
		iRST = 1'b0;
		check("txd", 32'(txd), 1);
		check("txBusy", 32'(txBusy), 0);
		check("rxEmpty", 32'(rxEmpty), 1);
		check("rxFull", 32'(rxFull), 0);
		check("rxOverflow", 32'(rxOverflow), 0);
		check("frameErr", 32'(frameErr), 0);
		for (int n = 0; n < Entries; n++)
		begin
			if (StimTable[n][9])
				sendLoopback(StimTable[n][7:0]);
			else
				receiveDirect(StimTable[n][7:0], StimTable[n][8]);
		end
		fillOverflow();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* hw/uartTop.sv */
module uartTop
(
	input logic iCLK,
	input logic iRST,
	input logic rxd,                    // serial in
	input logic rdStrobe,               // host pops one byte
	input logic sendStrobe,             // host starts a frame
	input uartPkg::byteT sendData,
	output logic txd,                   // serial out
	output logic rxThru,                // debug copy of rxd
	output uartPkg::byteT rdData,
	output logic rxEmpty,
	output logic rxFull,
	output logic rxOverflow,
	output logic frameErr,
	output logic txBusy
);

	uartPkg::byteT rxByte;              // decoder to FIFO
	logic rxValid;

	// ----------------------------------------
	// receive path
	// ----------------------------------------
	uartRx rxInst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.rxd(rxd),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.frameErr(frameErr),            // straight to the pin
		.rxThru(rxThru)
	);

	rxFifo fifoInst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.push(rxValid),                 // good frames only
		.pushData(rxByte),
		.pop(rdStrobe),
		.popData(rdData),
		.empty(rxEmpty),
		.full(rxFull),
		.overflow(rxOverflow)
	);

	// ----------------------------------------
	// transmit path
	// ----------------------------------------
	uartTx txInst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.sendStrobe(sendStrobe),
		.sendData(sendData),
		.txd(txd),
		.busy(txBusy)
	);

endmodule

/* hw/rxFifo.sv */
module rxFifo
(
	input logic iCLK,
	input logic iRST,
	input logic push,                   // write strobe
	input uartPkg::byteT pushData,
	input logic pop,                    // read strobe
	output uartPkg::byteT popData,      // oldest entry
	output logic empty,
	output logic full,
	output logic overflow               // sticky until reset
);

	uartPkg::byteT mem [uartPkg::FifoDepth];
	uartPkg::fifoPtrT wrPtr;
	uartPkg::fifoPtrT rdPtr;
	logic doPush;
	logic doPop;
	logic wrapDiff;                     // pointers on different laps
	logic addrSame;

	// ----------------------------------------
	// status from the pointers
	// ----------------------------------------
	assign wrapDiff = wrPtr[uartPkg::FifoAddrW] != rdPtr[uartPkg::FifoAddrW];
	assign addrSame = wrPtr[uartPkg::FifoAddrW-1:0] == rdPtr[uartPkg::FifoAddrW-1:0];
	assign empty = addrSame && !wrapDiff;
	assign full = addrSame && wrapDiff;

	assign doPush = push && !full;      // dropped when full
	assign doPop = pop && !empty;       // ignored when empty

	// ----------------------------------------
	// storage
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (doPush)
			mem[wrPtr[uartPkg::FifoAddrW-1:0]] <= pushData;
	end

	// show-ahead read port
	assign popData = mem[rdPtr[uartPkg::FifoAddrW-1:0]];

	// ----------------------------------------
	// pointers and overflow
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;  // wrap bit rolls over naturally
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			overflow <= 1'b0;
		else if (push && full)
			overflow <= 1'b1;           // a byte was lost
	end

endmodule

/* hw/uartTx.sv */
module uartTx
(
	input logic iCLK,
	input logic iRST,
	input logic sendStrobe,             // one-cycle request
	input uartPkg::byteT sendData,
	output logic txd,                   // serial pin, idles high
	output logic busy                   // high for the whole frame
);

	uartPkg::txStateT state;
	uartPkg::baudCntT baudCnt;
	uartPkg::bitCntT bitCnt;
	uartPkg::byteT shiftReg;            // bit 0 is next on the line
	logic bitTick;
	logic accept;

	assign bitTick = (baudCnt == uartPkg::baudCntT'(uartPkg::BaudDiv - 1));
	// strobes during a frame are dropped
	assign accept = sendStrobe && !busy && (state == uartPkg::txIdle);

	// ----------------------------------------
	// frame sequencer
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= uartPkg::txIdle;
			baudCnt <= '0;
			bitCnt <= '0;
		end
		else
		begin
			case (state)
				uartPkg::txIdle:
				begin
					baudCnt <= '0;
					bitCnt <= '0;
					if (accept)
						state <= uartPkg::txStart;
				end
				uartPkg::txStart:
				begin
					baudCnt <= bitTick ? '0 : baudCnt + 1'b1;
					if (bitTick)
						state <= uartPkg::txData;
				end
				uartPkg::txData:
				begin
					baudCnt <= bitTick ? '0 : baudCnt + 1'b1;
					if (bitTick)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == uartPkg::bitCntT'(7))
							state <= uartPkg::txStop;  // all eight out
					end
				end
				uartPkg::txStop:
				begin
					baudCnt <= bitTick ? '0 : baudCnt + 1'b1;
					if (bitTick)
						state <= uartPkg::txIdle;
				end
				default:
					state <= uartPkg::txIdle;
			endcase
		end
	end

	// byte latch and lsb-first shifter
	always_ff @(posedge iCLK)
	begin
		if (accept)
			shiftReg <= sendData;
		else if (state == uartPkg::txData && bitTick)
			shiftReg <= shiftReg >> 1;
	end

	// ----------------------------------------
	// output stage, one cycle behind the state
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			txd <= 1'b1;
			busy <= 1'b0;
		end
		else
		begin
			busy <= (state != uartPkg::txIdle);
			case (state)
				uartPkg::txStart: txd <= 1'b0;         // start bit
				uartPkg::txData: txd <= shiftReg[0];
				default: txd <= 1'b1;                  // stop bit and idle
			endcase
		end
	end

endmodule

/* hw/uartRx.sv */
module uartRx
(
	input logic iCLK,
	input logic iRST,
	input logic rxd,                    // raw serial pin
	output uartPkg::byteT rxByte,       // last assembled byte
	output logic rxValid,               // push pulse, good stop bit
	output logic frameErr,              // pulse, stop bit read low
	output logic rxThru                 // debug copy of the pin
);

	logic rxMeta;                       // first sync stage
	logic rxSync;                       // line as seen by the FSM
	uartPkg::rxStateT state;
	uartPkg::baudCntT baudCnt;
	uartPkg::bitCntT bitCnt;
	uartPkg::byteT shiftReg;            // first bit received ends up in bit 7
	logic centerHit;
	logic bitTick;

	// ----------------------------------------
	// debug thru copy
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		rxThru <= rxd;                  // one flop, no sync
	end

	// ----------------------------------------
	// line synchronizer
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rxMeta <= 1'b1;             // idle line level
			rxSync <= 1'b1;
		end
		else
		begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
		end
	end

	// half a bit after the start was seen
	assign centerHit = (baudCnt == uartPkg::baudCntT'(uartPkg::BaudDiv / 2 - 1));
	// one full bit after the last sample
	assign bitTick = (baudCnt == uartPkg::baudCntT'(uartPkg::BaudDiv - 1));

	// ----------------------------------------
	// decoder FSM
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= uartPkg::rxIdle;
			baudCnt <= '0;
			bitCnt <= '0;
			rxValid <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;            // one-shot by default
			frameErr <= 1'b0;
			case (state)
				uartPkg::rxIdle:
				begin
					baudCnt <= '0;
					bitCnt <= '0;
					if (!rxSync)
						state <= uartPkg::rxCenter;   // low seen, start bit
				end
				uartPkg::rxCenter:
				begin
					if (centerHit)
					begin
						baudCnt <= '0;
						// high again at the center means a glitch
						state <= rxSync ? uartPkg::rxIdle : uartPkg::rxData;
					end
					else
						baudCnt <= baudCnt + 1'b1;
				end
				uartPkg::rxData:
				begin
					if (bitTick)
					begin
						baudCnt <= '0;
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == uartPkg::bitCntT'(7))
							state <= uartPkg::rxStop;  // eighth bit taken
					end
					else
						baudCnt <= baudCnt + 1'b1;
				end
				uartPkg::rxStop:
				begin
					if (bitTick)
					begin
						rxValid <= rxSync;            // stop high, byte good
						frameErr <= !rxSync;          // stop low, drop it
						state <= uartPkg::rxIdle;
					end
					else
						baudCnt <= baudCnt + 1'b1;
				end
				default:
					state <= uartPkg::rxIdle;
			endcase
		end
	end

	// ----------------------------------------
	// data capture
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (state == uartPkg::rxData && bitTick)
			shiftReg <= {shiftReg[6:0], rxSync};   // msb-first shift
	end

	// line carries lsb first, so swap the bit order
	always_comb
	begin
		for (int i = 0; i < 8; i++)
		begin
			rxByte[i] = shiftReg[7 - i];
		end
	end

endmodule

/* hw/uartPkg.sv */
package uartPkg;

	// ----------------------------------------
	// baud timing
	// ----------------------------------------
	localparam int BaudDiv = 16;                 // clocks per serial bit
	localparam int BaudCntW = $clog2(BaudDiv);   // holds 0 .. BaudDiv-1

	// ----------------------------------------
	// receive FIFO sizing
	// ----------------------------------------
	localparam int FifoDepth = 8;                // power of two
	localparam int FifoAddrW = $clog2(FifoDepth);

	// data and counter vectors
	typedef logic [7:0] byteT;
	typedef logic [BaudCntW-1:0] baudCntT;
	typedef logic [3:0] bitCntT;                 // bit index within a frame
	typedef logic [FifoAddrW:0] fifoPtrT;        // top bit flips on wrap

	// receiver sequencing
	typedef enum logic [1:0] {
		rxIdle,      // waiting for start edge
		rxCenter,    // walking to middle of start bit
		rxData,      // eight data samples
		rxStop       // stop bit sample
	} rxStateT;

	// transmitter sequencing
	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txStateT;

endpackage
